//--- sources.f
spi_pkg.sv
led_pkg.sv
spi_cmd_if.sv
spi_slave_port.sv
led_cmd_decoder.sv
led_driver_spi_top.sv
tb_clock_gen.sv
tb_led_ctrl.sv

//--- Bender.yml
package:
  name: led_driver_spi

sources:
  - spi_pkg.sv
  - led_pkg.sv
  - spi_cmd_if.sv
  - spi_slave_port.sv
  - led_cmd_decoder.sv
  - led_driver_spi_top.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tb_led_ctrl.sv

//--- tb_led_ctrl.sv
// ########################################
// testbench for the LED driver host block
// bit-bangs SPI mode 0 frames, checks each
// frame against a model of the command set
// ########################################

`timescale 1ns/1ps

module tb_led_ctrl;
    import led_pkg::*;

    // sclk high and low phases in clocks, gap between frames
    localparam int SCLK_HALF   = 4;
    localparam int GAP_CLKS    = 10;
    localparam int FRAME_COUNT = 81;
    // longest frame is 64 bits plus lead, tail and gap
    localparam int FRAME_CLKS  = 2 * SCLK_HALF * 65 + GAP_CLKS;
    localparam int WATCHDOG_NS = 2 * FRAME_COUNT * FRAME_CLKS * 20;

    logic         clk;
    logic         reset;
    logic         spi_sclk;
    logic         spi_cs_n;
    logic         spi_mosi;
    logic         spi_miso;
    rotation_t    rotation_data;
    driver_conf_t configuration;
    logic         new_config_available;
    logic         rgb_enable;

    // model state
    driver_conf_t exp_conf;
    logic         exp_rgb;
    logic [47:0]  exp_reply;
    int           exp_pulses;

    integer       seed;
    int           pulse_count = 0;
    int           n_checks;
    int           n_errors;
    int           n_tests;
    int           tests_failed;
    int           test_err_start;
    logic [63:0]  rnd;
    logic [47:0]  miso_word;
    int           nbytes;
    int           req_len;

    tb_clock_gen clk_gen0 (
        .clk   (clk),
        .reset (reset)
    );

    led_driver_spi_top #(
        .SYNC_STAGES (2)
    ) dut0 (
        .clk                  (clk),
        .reset                (reset),
        .spi_sclk             (spi_sclk),
        .spi_cs_n             (spi_cs_n),
        .spi_mosi             (spi_mosi),
        .spi_miso             (spi_miso),
        .rotation_data        (rotation_data),
        .configuration        (configuration),
        .new_config_available (new_config_available),
        .rgb_enable           (rgb_enable)
    );

    // counts clocks with new_config_available high
    always @(negedge clk) begin
        if (new_config_available) begin
            pulse_count++;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("[FAIL] %s = %h, expected %h", name, got, exp);
        n_errors++;
    endtask

    // one frame, msb of data first, miso taken just before each sclk rise
    task automatic spi_transfer(input logic [63:0] data, input int bits);
        miso_word = '0;
        @(negedge clk);
        spi_cs_n = 1'b0;
        for (int i = 0; i < bits; i++) begin
            spi_mosi = data[63 - i];
            repeat (SCLK_HALF) @(negedge clk);
            if (i < 48) begin
                miso_word[47 - i] = spi_miso;
            end
            spi_sclk = 1'b1;
            repeat (SCLK_HALF) @(negedge clk);
            spi_sclk = 1'b0;
        end
        repeat (SCLK_HALF) @(negedge clk);
        spi_cs_n = 1'b1;
        spi_mosi = 1'b0;
        // decoder outputs settle within SYNC_STAGES+2 clocks
        repeat (GAP_CLKS) @(negedge clk);
    endtask

    // command rules: whole bytes only, opcode must match its length
    task automatic apply_model(input logic [63:0] data, input int bits);
        int len;
        len = (bits / 8 > 8) ? 8 : bits / 8;
        exp_pulses = 0;
        if (data[63:56] == OP_WRITE_CONF && len == 7) begin
            exp_conf   = data[55:8];
            exp_pulses = 1;
        end else if (data[63:56] == OP_SET_RGB && len == 2) begin
            exp_rgb = data[48];
        end else if (data[63:56] == OP_READ_ROT && len == 1) begin
            exp_reply = {rotation_data, 32'h0};
        end else if (data[63:56] == OP_READ_CONF && len == 1) begin
            exp_reply = exp_conf;
        end
    endtask

    task automatic run_frame(input logic [63:0] data, input int bits);
        int          pulses_before;
        logic [47:0] reply_before;
        logic [47:0] mask;
        pulses_before = pulse_count;
        reply_before  = exp_reply;
        // only clocked bits of the pending reply are visible
        mask = {48{1'b1}} << ((bits >= 48) ? 0 : 48 - bits);
        spi_transfer(data, bits);
        apply_model(data, bits);
        n_checks += 4;
        if ((miso_word & mask) !== (reply_before & mask)) begin
            report_mismatch("spi_miso", miso_word & mask, reply_before & mask);
        end
        if (configuration !== exp_conf) begin
            report_mismatch("configuration", configuration, exp_conf);
        end
        if (rgb_enable !== exp_rgb) begin
            report_mismatch("rgb_enable", rgb_enable, exp_rgb);
        end
        if (pulse_count - pulses_before != exp_pulses) begin
            report_mismatch("new_config_available pulses", pulse_count - pulses_before,
                            exp_pulses);
        end
    endtask

    task automatic report_test(input string name);
        n_tests++;
        if (n_errors == test_err_start) begin
            $display("test %0d %s: ok", n_tests, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", n_tests, name, n_errors - test_err_start);
        end
        test_err_start = n_errors;
    endtask

    initial begin
        seed           = 32'h8a3c_19a6;
        spi_sclk       = 1'b0;
        spi_cs_n       = 1'b1;
        spi_mosi       = 1'b0;
        rotation_data  = '0;
        exp_conf       = '0;
        exp_rgb        = 1'b0;
        exp_reply      = '0;
        exp_pulses     = 0;
        n_checks       = 0;
        n_errors       = 0;
        n_tests        = 0;
        tests_failed   = 0;
        test_err_start = 0;
        wait (reset === 1'b0);
        @(negedge clk);

        // reset state, then a 48 bit frame with opcode 00 fetches the reply
        n_checks += 3;
        if (configuration !== '0) begin
            report_mismatch("configuration", configuration, 64'h0);
        end
        if (rgb_enable !== 1'b0) begin
            report_mismatch("rgb_enable", rgb_enable, 64'h0);
        end
        if (new_config_available !== 1'b0) begin
            report_mismatch("new_config_available", new_config_available, 64'h0);
        end
        run_frame(64'h0, 48);
        report_test("reset state");

        repeat (20) begin
            rnd = {$random(seed), $random(seed)};
            run_frame({OP_WRITE_CONF, rnd[47:0], 8'h00}, 56);
        end
        report_test("configuration write");

        repeat (16) begin
            rnd = {$random(seed), $random(seed)};
            run_frame({OP_SET_RGB, rnd[55:0]}, 16);
        end
        report_test("rgb enable");

        repeat (4) begin
            @(negedge clk);
            rotation_data = rotation_t'($random(seed));
            run_frame({OP_READ_ROT, 56'h0}, 8);
            run_frame(64'h0, 48);
        end
        report_test("rotation read");

        repeat (4) begin
            rnd = {$random(seed), $random(seed)};
            run_frame({OP_WRITE_CONF, rnd[47:0], 8'h00}, 56);
            run_frame({OP_READ_CONF, 56'h0}, 8);
            run_frame(64'h0, 48);
        end
        report_test("configuration read");

        // pending reply first, so a disturbed reply shows up
        @(negedge clk);
        rotation_data = rotation_t'($random(seed));
        run_frame({OP_READ_ROT, 56'h0}, 8);
        for (int i = 0; i < 8; i++) begin
            rnd = {$random(seed), $random(seed)};
            if (rnd[63:56] >= 8'h01 && rnd[63:56] <= 8'h04) begin
                rnd[63:56] = rnd[63:56] + 8'h40;
            end
            run_frame(rnd, 8 * (1 + rnd[2:0]));
        end
        // known opcodes at a length other than their own
        for (int i = 0; i < 8; i++) begin
            rnd        = {$random(seed), $random(seed)};
            rnd[63:56] = 8'(1 + i % 4);
            req_len    = (i % 4 == 1) ? 7 : ((i % 4 == 2) ? 2 : 1);
            nbytes     = 1 + rnd[2:0];
            if (nbytes == req_len) begin
                nbytes = nbytes % 8 + 1;
            end
            run_frame(rnd, 8 * nbytes);
        end
        // writes cut mid-byte leave six whole bytes
        repeat (6) begin
            rnd = {$random(seed), $random(seed)};
            run_frame({OP_WRITE_CONF, rnd[55:0]}, 49 + rnd[63:56] % 7);
        end
        run_frame(64'h0, 48);
        report_test("malformed frames");

        $display("tests: %0d, failed: %0d, checks: %0d, errors: %0d",
                 n_tests, tests_failed, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- tb_clock_gen.sv
// ########################################
// testbench clock and reset source
// 20 ns clock, reset high for two cycles
// ########################################

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // release on a falling edge, same as the other DUT inputs
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

//--- led_driver_spi_top.sv
// ########################################
// host command block of the LED driver
// board. SPI pins in, driver configuration
// and RGB enable out. set SYNC_STAGES for
// the pin synchronizer depth (2 or more)
// ########################################

`timescale 1ns/1ps

module led_driver_spi_top #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  spi_sclk,
    input  logic                  spi_cs_n,
    input  logic                  spi_mosi,
    output logic                  spi_miso,
    input  led_pkg::rotation_t    rotation_data,
    output led_pkg::driver_conf_t configuration,
    output logic                  new_config_available,
    output logic                  rgb_enable
);

    // frame and reply path between port and decoder
    spi_cmd_if cmd_link ();

    // pins to frames, replies to miso
    spi_slave_port #(
        .SYNC_STAGES (SYNC_STAGES)
    ) spi_port0 (
        .clk      (clk),
        .reset    (reset),
        .spi_sclk (spi_sclk),
        .spi_cs_n (spi_cs_n),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso),
        .cmd      (cmd_link.port)
    );

    // frames to device state and replies
    led_cmd_decoder cmd_decoder0 (
        .clk                  (clk),
        .reset                (reset),
        .rotation_data        (rotation_data),
        .configuration        (configuration),
        .new_config_available (new_config_available),
        .rgb_enable           (rgb_enable),
        .cmd                  (cmd_link.decoder)
    );

endmodule

//--- led_cmd_decoder.sv
// ########################################
// decodes SPI command frames for the LED
// driver: config write, RGB enable and the
// two read commands that load a reply
// ########################################

`timescale 1ns/1ps

module led_cmd_decoder (
    input  logic                  clk,
    input  logic                  reset,
    input  led_pkg::rotation_t    rotation_data,
    output led_pkg::driver_conf_t configuration,
    output logic                  new_config_available,
    output logic                  rgb_enable,
    spi_cmd_if.decoder            cmd
);
    import spi_pkg::*;
    import led_pkg::*;

    localparam int FRAME_BITS = $bits(spi_frame_t);
    localparam int REPLY_BITS = $bits(spi_reply_t);
    localparam int CONF_BITS  = $bits(driver_conf_t);
    localparam int ROT_BITS   = $bits(rotation_t);

    led_opcode_t  opcode;
    driver_conf_t conf_field;
    logic         rgb_field;
    logic         len_ok;
    spi_reply_t   reply_q;
    logic         reply_load_q;

    // opcode is byte 0, payload follows
    assign opcode     = led_opcode_t'(cmd.frame[FRAME_BITS-1 -: SPI_BYTE_BITS]);
    assign conf_field = cmd.frame[FRAME_BITS-SPI_BYTE_BITS-1 -: CONF_BITS];
    // enable is bit 0 of byte 1
    assign rgb_field  = cmd.frame[FRAME_BITS-2*SPI_BYTE_BITS];

    // length check per opcode, unknown opcodes never pass
    always_comb begin
        case (opcode)
            OP_READ_ROT:   len_ok = (cmd.len == spi_len_t'(LEN_READ_ROT));
            OP_WRITE_CONF: len_ok = (cmd.len == spi_len_t'(LEN_WRITE_CONF));
            OP_SET_RGB:    len_ok = (cmd.len == spi_len_t'(LEN_SET_RGB));
            OP_READ_CONF:  len_ok = (cmd.len == spi_len_t'(LEN_READ_CONF));
            default:       len_ok = 1'b0;
        endcase
    end

    // device state and strobes, all update one clock after valid
    always_ff @(posedge clk) begin
        if (reset) begin
            configuration        <= '0;
            new_config_available <= 1'b0;
            rgb_enable           <= 1'b0;
            reply_load_q         <= 1'b0;
        end else begin
            new_config_available <= 1'b0;
            reply_load_q         <= 1'b0;
            if (cmd.valid && len_ok) begin
                case (opcode)
                    OP_WRITE_CONF: begin
                        configuration        <= conf_field;
                        new_config_available <= 1'b1;
                    end
                    OP_SET_RGB: rgb_enable <= rgb_field;
                    // both reads hand a reply to the port
                    default: reply_load_q <= 1'b1;
                endcase
            end
        end
    end

    // reply payload, only meaningful while reply_load is high
    always_ff @(posedge clk) begin
        if (cmd.valid && opcode == OP_READ_ROT) begin
            // rotation in the top bits, zeros behind it
            reply_q <= {rotation_data, {(REPLY_BITS - ROT_BITS){1'b0}}};
        end else if (cmd.valid) begin
            reply_q <= spi_reply_t'(configuration);
        end
    end

    assign cmd.reply      = reply_q;
    assign cmd.reply_load = reply_load_q;

endmodule

//--- spi_slave_port.sv
// ########################################
// SPI mode 0 slave sampled by the system
// clock. collects a frame of up to eight
// bytes, strobes it on chip select rise,
// and shifts the stored reply out on miso
// ########################################

`timescale 1ns/1ps

module spi_slave_port #(
    parameter int SYNC_STAGES = 2
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    spi_sclk,
    input  logic    spi_cs_n,
    input  logic    spi_mosi,
    output logic    spi_miso,
    spi_cmd_if.port cmd
);
    import spi_pkg::*;

    localparam int REPLY_BITS = $bits(spi_reply_t);
    // pin order in the sync chain is {sclk, cs_n, mosi}
    localparam logic [2:0] PIN_IDLE = 3'b010;

    logic [SYNC_STAGES-1:0][2:0] pin_sync;
    logic sclk_s;
    logic cs_n_s;
    logic mosi_s;
    logic sclk_prev;
    logic cs_n_prev;
    logic sclk_rise;
    logic sclk_fall;
    logic cs_rise;
    logic cs_fall;
    logic cs_active;

    logic [2:0]                 bit_cnt;
    logic [SPI_BYTE_BITS-2:0]   rx_bits;
    spi_len_t                   byte_cnt;
    spi_frame_t                 frame_q;
    logic                       valid_q;
    spi_reply_t                 reply_q;
    spi_reply_t                 tx_shift;

    // pin synchronizer, idles as sclk low and cs_n high
    always_ff @(posedge clk) begin
        if (reset) begin
            pin_sync  <= {SYNC_STAGES{PIN_IDLE}};
            sclk_prev <= 1'b0;
            cs_n_prev <= 1'b1;
        end else begin
            pin_sync  <= {pin_sync[SYNC_STAGES-2:0], {spi_sclk, spi_cs_n, spi_mosi}};
            sclk_prev <= sclk_s;
            cs_n_prev <= cs_n_s;
        end
    end

    assign sclk_s = pin_sync[SYNC_STAGES-1][2];
    assign cs_n_s = pin_sync[SYNC_STAGES-1][1];
    assign mosi_s = pin_sync[SYNC_STAGES-1][0];

    // edge detect on the synchronized pins
    assign sclk_rise = sclk_s & ~sclk_prev;
    assign sclk_fall = ~sclk_s & sclk_prev;
    assign cs_rise   = cs_n_s & ~cs_n_prev;
    assign cs_fall   = ~cs_n_s & cs_n_prev;
    assign cs_active = ~cs_n_s;

    // partial byte shifter, holds the first seven bits of a byte
    always_ff @(posedge clk) begin
        if (cs_active && sclk_rise) begin
            rx_bits <= {rx_bits[SPI_BYTE_BITS-3:0], mosi_s};
        end
    end

    // byte counting and frame packing, mosi sampled on sclk rise
    always_ff @(posedge clk) begin
        if (reset || cs_fall) begin
            bit_cnt  <= '0;
            byte_cnt <= '0;
            frame_q  <= '0;
        end else if (cs_active && sclk_rise) begin
            bit_cnt <= bit_cnt + 3'd1;
            // eighth bit completes a byte, bytes past the eighth are dropped
            if (bit_cnt == 3'd7 && byte_cnt < SPI_MAX_BYTES) begin
                frame_q[(SPI_MAX_BYTES - 1 - byte_cnt) * SPI_BYTE_BITS +: SPI_BYTE_BITS]
                    <= {rx_bits, mosi_s};
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

    // one clock strobe when chip select releases
    // a frame without a whole byte is not reported
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= cs_rise && (byte_cnt != '0);
        end
    end

    assign cmd.frame = frame_q;
    assign cmd.len   = byte_cnt;
    assign cmd.valid = valid_q;

    // reply register, held until the decoder loads a new one
    always_ff @(posedge clk) begin
        if (reset) begin
            reply_q <= '0;
        end else if (cmd.reply_load) begin
            reply_q <= cmd.reply;
        end
    end

    // transmit shifter
    // loaded at frame start, shifted after each sclk fall, zero filled
    always_ff @(posedge clk) begin
        if (reset || cs_rise) begin
            tx_shift <= '0;
        end else if (cs_fall) begin
            tx_shift <= reply_q;
        end else if (cs_active && sclk_fall) begin
            tx_shift <= {tx_shift[REPLY_BITS-2:0], 1'b0};
        end
    end

    assign spi_miso = tx_shift[REPLY_BITS-1];

endmodule

//--- spi_cmd_if.sv
// ########################################
// link between the SPI slave port and the
// command decoder: received frame one way,
// reply word the other way
// ########################################

`timescale 1ns/1ps

interface spi_cmd_if;
    import spi_pkg::*;

    // received frame, valid pulses one clock per frame
    spi_frame_t frame;
    spi_len_t   len;
    logic       valid;

    // reply for the next frame, taken when reply_load is high
    spi_reply_t reply;
    logic       reply_load;

    // SPI side: produces frames, consumes replies
    modport port (
        output frame, len, valid,
        input  reply, reply_load
    );

    // decoder side: no stall, takes every valid
    modport decoder (
        input  frame, len, valid,
        output reply, reply_load
    );

endinterface

//--- led_pkg.sv
// ########################################
// LED driver command set and device state
// types (rotation, driver configuration)
// used by the decoder and the top level
// ########################################

package led_pkg;

    // opcode is the first byte of every frame
    typedef enum logic [7:0] {
        OP_READ_ROT   = 8'h01,
        OP_WRITE_CONF = 8'h02,
        OP_SET_RGB    = 8'h03,
        OP_READ_CONF  = 8'h04
    } led_opcode_t;

    // required frame length per opcode, in bytes
    localparam int LEN_READ_ROT   = 1;
    // opcode plus six configuration bytes
    localparam int LEN_WRITE_CONF = 7;
    // opcode plus enable byte
    localparam int LEN_SET_RGB    = 2;
    localparam int LEN_READ_CONF  = 1;

    // rotation sensor reading
    typedef logic [15:0] rotation_t;

    // LED driver configuration word
    typedef logic [47:0] driver_conf_t;

endpackage

//--- spi_pkg.sv
// ########################################
// SPI frame sizes and types shared by the
// slave port, the command interface and
// the command decoder
// import inside a module body or scope names
// ########################################

package spi_pkg;

    // bits per SPI byte
    localparam int SPI_BYTE_BITS = 8;

    // most bytes kept per frame, later bytes are dropped
    localparam int SPI_MAX_BYTES = 8;

    // reply length sent back on miso
    localparam int SPI_REPLY_BYTES = 6;

    // received frame, first byte in the top eight bits
    // unused low bytes stay zero
    typedef logic [SPI_MAX_BYTES*SPI_BYTE_BITS-1:0] spi_frame_t;

    // count of whole bytes received, 1 to 8
    typedef logic [3:0] spi_len_t;

    // reply word, msb goes out first
    typedef logic [SPI_REPLY_BYTES*SPI_BYTE_BITS-1:0] spi_reply_t;

endpackage
